//--- logic/cmp_lane_buffer.sv
// Circular FIFO of lane jobs with valid/ready on both sides.
`default_nettype none

module cmp_lane_buffer #(
  parameter int unsigned Depth = 2
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  lane_bus_if.dst wr,
  lane_bus_if.src rd
);

  // Pointer and occupancy widths.
  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  localparam logic [PtrW-1:0] LastPtr = PtrW'(Depth - 1);
  localparam logic [CntW-1:0] FullCnt = CntW'(Depth);

  // Advance a pointer around the ring.
  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    if (ptr == LastPtr) begin
      return '0;
    end
    return ptr + PtrW'(1);
  endfunction

  // Entry storage.
  fpcmp_pkg::fp_fmt_e    fmt_q    [Depth];
  fpcmp_pkg::lane_mask_t lt_q     [Depth];
  fpcmp_pkg::lane_mask_t nv_q     [Depth];
  fpcmp_pkg::lane_mask_t active_q [Depth];
  fpcmp_pkg::lane_mask_t mask_q   [Depth];

  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push;
  logic            pop;

  // Full blocks writes even when a read happens the same cycle.
  assign wr.ready = (count_q != FullCnt);
  assign rd.valid = (count_q != '0);

  assign push = wr.valid & wr.ready;
  assign pop  = rd.valid & rd.ready;

  // Pointers and occupancy.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + CntW'(1);
      end else if (pop && !push) begin
        count_q <= count_q - CntW'(1);
      end
    end
  end

  // Write the job at the tail.
  always_ff @(posedge clk_i) begin
    if (push) begin
      fmt_q[wr_ptr_q]    <= wr.fmt;
      lt_q[wr_ptr_q]     <= wr.lt_bits;
      nv_q[wr_ptr_q]     <= wr.nv_bits;
      active_q[wr_ptr_q] <= wr.active;
      mask_q[wr_ptr_q]   <= wr.mask;
    end
  end

  // Head entry is visible the cycle after it was written.
  assign rd.fmt     = fmt_q[rd_ptr_q];
  assign rd.lt_bits = lt_q[rd_ptr_q];
  assign rd.nv_bits = nv_q[rd_ptr_q];
  assign rd.active  = active_q[rd_ptr_q];
  assign rd.mask    = mask_q[rd_ptr_q];

endmodule

`default_nettype wire

//--- logic/cmp_lane_dispatch.sv
// Dispatch stage with lane slicing, NaN classification and per-lane FP compare.
`default_nettype none

module cmp_lane_dispatch (
  input  fpcmp_pkg::data_t      operand_a_i,
  input  fpcmp_pkg::data_t      operand_b_i,
  input  fpcmp_pkg::fp_fmt_e    fmt_i,
  input  fpcmp_pkg::cmp_op_e    op_i,
  input  logic                  vectorial_op_i,
  input  fpcmp_pkg::lane_mask_t simd_mask_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  lane_bus_if.src               bus
);

  // Sign bit positions, also the magnitude widths.
  localparam int unsigned F32Sign = fpcmp_pkg::FP32_EXP_BITS + fpcmp_pkg::FP32_MAN_BITS;
  localparam int unsigned F16Sign = fpcmp_pkg::FP16_EXP_BITS + fpcmp_pkg::FP16_MAN_BITS;

  // Magnitude is held at FP32 width.
  localparam int unsigned MagBits = F32Sign;

  // Split a right-aligned value into sign, magnitude and NaN class.
  function automatic void unpack_fp(
    input  fpcmp_pkg::data_t   value,
    input  fpcmp_pkg::fp_fmt_e fmt,
    output logic               sign,
    output logic [MagBits-1:0] mag,
    output logic               nan,
    output logic               snan
  );
    logic exp_ones;
    logic man_nz;
    logic quiet;
    if (fmt == fpcmp_pkg::FP32) begin
      sign     = value[F32Sign];
      exp_ones = &value[F32Sign-1 -: fpcmp_pkg::FP32_EXP_BITS];
      man_nz   = |value[fpcmp_pkg::FP32_MAN_BITS-1:0];
      quiet    = value[fpcmp_pkg::FP32_MAN_BITS-1];
      mag      = value[F32Sign-1:0];
    end else begin
      sign     = value[F16Sign];
      exp_ones = &value[F16Sign-1 -: fpcmp_pkg::FP16_EXP_BITS];
      man_nz   = |value[fpcmp_pkg::FP16_MAN_BITS-1:0];
      quiet    = value[fpcmp_pkg::FP16_MAN_BITS-1];
      mag      = {{(MagBits-F16Sign){1'b0}}, value[F16Sign-1:0]};
    end
    // All-ones exponent with a non-zero mantissa is a NaN.
    nan  = exp_ones & man_nz;
    // Signaling NaN has the top mantissa bit clear.
    snan = nan & ~quiet;
  endfunction

  // The upper lane only joins for a vectorial FP16 request.
  logic upper_active;

  assign upper_active = vectorial_op_i & (fmt_i == fpcmp_pkg::FP16);

  for (genvar i = 0; i < int'(fpcmp_pkg::NUM_LANES); i++) begin : g_lane
    fpcmp_pkg::data_t   lane_a;
    fpcmp_pkg::data_t   lane_b;
    logic               sign_a;
    logic               sign_b;
    logic [MagBits-1:0] mag_a;
    logic [MagBits-1:0] mag_b;
    logic               nan_a;
    logic               nan_b;
    logic               snan_a;
    logic               snan_b;
    logic               any_nan;
    logic               both_zero;
    logic               equal;
    logic               less;

    // Lane operands sit one FP16 slot apart.
    assign lane_a = operand_a_i >> (i * fpcmp_pkg::FP16_WIDTH);
    assign lane_b = operand_b_i >> (i * fpcmp_pkg::FP16_WIDTH);

    always_comb begin
      unpack_fp(lane_a, fmt_i, sign_a, mag_a, nan_a, snan_a);
      unpack_fp(lane_b, fmt_i, sign_b, mag_b, nan_b, snan_b);

      any_nan   = nan_a | nan_b;
      // Signed zeros compare equal.
      both_zero = (mag_a == '0) && (mag_b == '0);
      equal     = !any_nan && (({sign_a, mag_a} == {sign_b, mag_b}) || both_zero);

      // Sign-magnitude ordering.
      if (any_nan || both_zero) begin
        less = 1'b0;
      end else if (sign_a != sign_b) begin
        less = sign_a;
      end else if (sign_a) begin
        // Both negative, larger magnitude is smaller.
        less = mag_a > mag_b;
      end else begin
        less = mag_a < mag_b;
      end

      // Result bit and invalid flag per operation.
      case (op_i)
        fpcmp_pkg::CMP_EQ: begin
          bus.lt_bits[i] = equal;
          bus.nv_bits[i] = snan_a | snan_b;
        end
        fpcmp_pkg::CMP_LT: begin
          bus.lt_bits[i] = less;
          bus.nv_bits[i] = any_nan;
        end
        fpcmp_pkg::CMP_LE: begin
          bus.lt_bits[i] = less | equal;
          bus.nv_bits[i] = any_nan;
        end
        default: begin
          bus.lt_bits[i] = 1'b0;
          bus.nv_bits[i] = 1'b0;
        end
      endcase
    end

    // Lane 0 always takes part.
    assign bus.active[i] = (i == 0) ? 1'b1 : upper_active;
  end

  // Job fields straight from the request.
  assign bus.valid = in_valid_i;
  assign bus.fmt   = fmt_i;
  assign bus.mask  = simd_mask_i;

  // Backpressure comes from the buffer.
  assign in_ready_o = bus.ready;

endmodule

`default_nettype wire

//--- logic/cmp_result_merge.sv
// Merge stage packing lane result bits into the output word and ORing masked status flags.
`default_nettype none

module cmp_result_merge (
  lane_bus_if.dst           bus,
  input  logic              out_ready_i,
  output logic              out_valid_o,
  output fpcmp_pkg::data_t  result_o,
  output fpcmp_pkg::status_t status_o
);

  // Result bits of lanes in use.
  fpcmp_pkg::lane_mask_t lane_bits;
  // Flags of lanes in use and enabled by the SIMD mask.
  fpcmp_pkg::lane_mask_t lane_nv;

  assign lane_bits = bus.lt_bits & bus.active;
  assign lane_nv   = bus.nv_bits & bus.active & bus.mask;

  // Compare results are integers, all other bits stay zero.
  always_comb begin
    result_o = '0;
    if (bus.fmt == fpcmp_pkg::FP32) begin
      // Single lane, bit 0 of the word.
      result_o[0] = lane_bits[0];
    end else begin
      // Bottom bit of each FP16 slot.
      for (int i = 0; i < int'(fpcmp_pkg::NUM_LANES); i++) begin
        result_o[i*fpcmp_pkg::FP16_WIDTH] = lane_bits[i];
      end
    end
  end

  // Only NV can be raised by a compare.
  always_comb begin
    status_o = '0;
    status_o[fpcmp_pkg::STATUS_NV] = |lane_nv;
  end

  // Handshake passes straight through.
  assign out_valid_o = bus.valid;
  assign bus.ready   = out_ready_i;

endmodule

`default_nettype wire

//--- logic/fpcmp_pkg.sv
// Compare slice package with data, format, operation, status and lane mask types and field widths.
`default_nettype none

package fpcmp_pkg;

  // Datapath width, one FP32 value or two FP16 lanes.
  localparam int unsigned DATA_WIDTH = 32;

  // Number of SIMD lanes in the datapath.
  localparam int unsigned NUM_LANES = 2;

  // FP32 field widths.
  localparam int unsigned FP32_EXP_BITS = 8;
  localparam int unsigned FP32_MAN_BITS = 23;

  // FP16 field widths.
  localparam int unsigned FP16_EXP_BITS = 5;
  localparam int unsigned FP16_MAN_BITS = 10;

  // Width of one FP16 slot, also the lane stride in the data word.
  localparam int unsigned FP16_WIDTH = 1 + FP16_EXP_BITS + FP16_MAN_BITS;

  // Bit position of the invalid flag in the status vector.
  localparam int unsigned STATUS_NV = 4;

  // One packed data word.
  typedef logic [DATA_WIDTH-1:0] data_t;

  // One bit per SIMD lane.
  typedef logic [NUM_LANES-1:0] lane_mask_t;

  // Status flags NV, DZ, OF, UF, NX from top bit down.
  typedef logic [4:0] status_t;

  // Supported FP formats.
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_fmt_e;

  // Supported compare operations.
  // EQ is quiet, LT and LE are signaling.
  typedef enum logic [1:0] {
    CMP_EQ = 2'd0,
    CMP_LT = 2'd1,
    CMP_LE = 2'd2
  } cmp_op_e;

endpackage

`default_nettype wire

//--- logic/fpcmp_slice_top.sv
// Top level of the FP compare slice with dispatch, lane buffer and result merge.
`default_nettype none

module fpcmp_slice_top #(
  parameter int unsigned Depth = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // Request side.
  input  fpcmp_pkg::data_t      operand_a_i,
  input  fpcmp_pkg::data_t      operand_b_i,
  input  fpcmp_pkg::fp_fmt_e    fmt_i,
  input  fpcmp_pkg::cmp_op_e    op_i,
  input  logic                  vectorial_op_i,
  input  fpcmp_pkg::lane_mask_t simd_mask_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,

  // Result side.
  output fpcmp_pkg::data_t      result_o,
  output fpcmp_pkg::status_t    status_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i
);

  // Dispatch to buffer.
  lane_bus_if disp_bus ();
  // Buffer to merge.
  lane_bus_if merge_bus ();

  // Lane compare, combinational.
  cmp_lane_dispatch u_dispatch (
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .fmt_i          (fmt_i),
    .op_i           (op_i),
    .vectorial_op_i (vectorial_op_i),
    .simd_mask_i    (simd_mask_i),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .bus            (disp_bus.src)
  );

  // The only registered stage.
  cmp_lane_buffer #(
    .Depth (Depth)
  ) u_buffer (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .wr     (disp_bus.dst),
    .rd     (merge_bus.src)
  );

  // Result packing and status merge, combinational.
  cmp_result_merge u_merge (
    .bus         (merge_bus.dst),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o),
    .result_o    (result_o),
    .status_o    (status_o)
  );

endmodule

`default_nettype wire

//--- logic/lane_bus_if.sv
// Lane job interface with source and destination modports.
`default_nettype none

interface lane_bus_if;

  // Handshake pair.
  logic valid;
  logic ready;

  // Format of the job, picks the result packing.
  fpcmp_pkg::fp_fmt_e fmt;

  // Per-lane compare result bits.
  fpcmp_pkg::lane_mask_t lt_bits;

  // Per-lane invalid flags before masking.
  fpcmp_pkg::lane_mask_t nv_bits;

  // Lanes that belong to the request.
  fpcmp_pkg::lane_mask_t active;

  // SIMD mask for the status merge.
  fpcmp_pkg::lane_mask_t mask;

  // Producer side.
  modport src (
    output valid,
    output fmt,
    output lt_bits,
    output nv_bits,
    output active,
    output mask,
    input  ready
  );

  // Consumer side.
  modport dst (
    input  valid,
    input  fmt,
    input  lt_bits,
    input  nv_bits,
    input  active,
    input  mask,
    output ready
  );

endinterface

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the compare slice testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_fpcmp_slice -o sim_fpcmp
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_fpcmp)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1

//--- src.f
+incdir+tb
logic/fpcmp_pkg.sv
logic/lane_bus_if.sv
logic/cmp_lane_dispatch.sv
logic/cmp_lane_buffer.sv
logic/cmp_result_merge.sv
logic/fpcmp_slice_top.sv
tb/tb_fpcmp_slice.sv

//--- tb/fpcmp_ref.svh
// Reference model of the compare slice, with builders for FP16 and FP32 values.
`default_nettype none

// Split one value into NaN class and a signed ordering key.
// Both zeros map to key 0, so they compare equal.
function automatic void classify(
  input  logic [31:0] v,
  input  int unsigned ew,
  input  int unsigned mw,
  output logic        nan,
  output logic        snan,
  output longint      key
);
  logic [31:0] exp_f;
  logic [31:0] man_f;
  logic [31:0] mag;
  logic        sign;
  exp_f = (v >> mw) & ((32'd1 << ew) - 32'd1);
  man_f = v & ((32'd1 << mw) - 32'd1);
  mag   = v & ((32'd1 << (ew + mw)) - 32'd1);
  sign  = ((v >> (ew + mw)) & 32'd1) != 32'd0;
  nan   = (exp_f == ((32'd1 << ew) - 32'd1)) && (man_f != 32'd0);
  // The top mantissa bit marks a quiet NaN.
  snan  = nan && (((man_f >> (mw - 1)) & 32'd1) == 32'd0);
  key   = sign ? -longint'(mag) : longint'(mag);
endfunction

// Result bit and NV flag of one lane.
function automatic void ref_lane(
  input  logic [31:0]        a,
  input  logic [31:0]        b,
  input  logic               is16,
  input  fpcmp_pkg::cmp_op_e op,
  output logic               res,
  output logic               nv
);
  int unsigned ew;
  int unsigned mw;
  logic        nan_a, nan_b, snan_a, snan_b;
  longint      key_a, key_b;
  ew = is16 ? fpcmp_pkg::FP16_EXP_BITS : fpcmp_pkg::FP32_EXP_BITS;
  mw = is16 ? fpcmp_pkg::FP16_MAN_BITS : fpcmp_pkg::FP32_MAN_BITS;
  classify(a, ew, mw, nan_a, snan_a, key_a);
  classify(b, ew, mw, nan_b, snan_b, key_b);
  case (op)
    fpcmp_pkg::CMP_EQ: begin
      res = !(nan_a || nan_b) && (key_a == key_b);
      // Quiet equal flags only signaling NaNs.
      nv  = snan_a || snan_b;
    end
    fpcmp_pkg::CMP_LT: begin
      res = !(nan_a || nan_b) && (key_a < key_b);
      nv  = nan_a || nan_b;
    end
    default: begin
      res = !(nan_a || nan_b) && (key_a <= key_b);
      nv  = nan_a || nan_b;
    end
  endcase
endfunction

// Expected {status, result} of one request.
function automatic logic [36:0] ref_cmp(
  input logic [31:0]        a,
  input logic [31:0]        b,
  input logic               is16,
  input fpcmp_pkg::cmp_op_e op,
  input logic               vec,
  input logic [1:0]         mask
);
  logic [31:0] res;
  logic [4:0]  st;
  logic        bit_r;
  logic        nv;
  res = 32'd0;
  st  = 5'd0;
  // A FP16 lane sees only its own 16 bits.
  ref_lane(is16 ? {16'd0, a[15:0]} : a, is16 ? {16'd0, b[15:0]} : b, is16, op, bit_r, nv);
  res[0] = bit_r;
  // NV is the top status bit.
  st[4]  = nv & mask[0];
  if (is16 && vec) begin
    ref_lane({16'd0, a[31:16]}, {16'd0, b[31:16]}, 1'b1, op, bit_r, nv);
    res[16] = bit_r;
    st[4]   = st[4] | (nv & mask[1]);
  end
  return {st, res};
endfunction

function automatic logic [15:0] make_fp16(input logic s, input logic [4:0] e, input logic [9:0] m);
  return {s, e, m};
endfunction

function automatic logic [31:0] make_fp32(input logic s, input logic [7:0] e,
                                          input logic [22:0] m);
  return {s, e, m};
endfunction

`default_nettype wire

//--- tb/tb_fpcmp_slice.sv
// Testbench top for the FP compare slice with stimulus, comparing process, timeout and report.
`include "fpcmp_ref.svh"
`default_nettype none

module tb_fpcmp_slice;

  localparam int unsigned DEPTH = 2;
  localparam int unsigned NUM_RANDOM = 200;
  // 25 directed requests, DEPTH back-pressure requests and the random ones.
  localparam int unsigned NUM_REQS = 25 + DEPTH + NUM_RANDOM;
  localparam int unsigned TIMEOUT_CYCLES = 10 * NUM_REQS + 50;

  localparam fpcmp_pkg::cmp_op_e EQ = fpcmp_pkg::CMP_EQ;
  localparam fpcmp_pkg::cmp_op_e LT = fpcmp_pkg::CMP_LT;
  localparam fpcmp_pkg::cmp_op_e LE = fpcmp_pkg::CMP_LE;

  logic                  clk_i;
  logic                  rst_ni;
  fpcmp_pkg::data_t      operand_a_i;
  fpcmp_pkg::data_t      operand_b_i;
  fpcmp_pkg::fp_fmt_e    fmt_i;
  fpcmp_pkg::cmp_op_e    op_i;
  logic                  vectorial_op_i;
  fpcmp_pkg::lane_mask_t simd_mask_i;
  logic                  in_valid_i;
  logic                  in_ready_o;
  fpcmp_pkg::data_t      result_o;
  fpcmp_pkg::status_t    status_o;
  logic                  out_valid_o;
  logic                  out_ready_i;

  // Expected {status, result} of each request in order.
  logic [36:0] exp_q [$];
  logic [36:0] exp_v;
  int          rd_idx = 0;
  int          cmp_checks = 0;
  int          cmp_errors = 0;
  int          misc_checks = 0;
  int          misc_errors = 0;
  int          base_checks;
  int          base_errors;
  int          cycles = 0;
  int          seed = 16;
  // 0 keeps out_ready_i high, 1 holds it low, 2 randomizes it.
  int          ready_mode = 0;
  string       cur_test;

  logic [31:0]        rnd_a   [NUM_RANDOM];
  logic [31:0]        rnd_b   [NUM_RANDOM];
  logic [31:0]        rnd_ctl [NUM_RANDOM];
  fpcmp_pkg::cmp_op_e rnd_op;

  logic [31:0] one32, two32, mone32, nzero32, qnan32, snan32;
  logic [15:0] one16, two16, mtwo16, qnan16, snan16;

  fpcmp_slice_top #(
    .Depth (DEPTH)
  ) u_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .fmt_i          (fmt_i),
    .op_i           (op_i),
    .vectorial_op_i (vectorial_op_i),
    .simd_mask_i    (simd_mask_i),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .result_o       (result_o),
    .status_o       (status_o),
    .out_valid_o    (out_valid_o),
    .out_ready_i    (out_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Random data is drawn up front, then out_ready_i follows ready_mode.
  initial begin
    out_ready_i = 1'b1;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rnd_ctl[i] = $random(seed);
      rnd_a[i]   = $random(seed);
      rnd_b[i]   = $random(seed);
      // Push some operands to all-ones exponents, so NaNs turn up often.
      if (rnd_ctl[i][13:12] == 2'd0) begin
        rnd_a[i][30:23] = 8'hFF;
        rnd_a[i][14:10] = 5'h1F;
      end
      // Equal pairs.
      if (rnd_ctl[i][15:14] == 2'd0) begin
        rnd_b[i] = rnd_a[i];
      end
    end
    forever begin
      @(negedge clk_i);
      if (ready_mode == 2) begin
        out_ready_i = 1'($random(seed));
      end else begin
        out_ready_i = (ready_mode == 0);
      end
    end
  end

  // Compare each output handshake with the next expected entry.
  always @(posedge clk_i) begin
    if (rst_ni && out_valid_o && out_ready_i) begin
      if (rd_idx >= exp_q.size()) begin
        $display("Extra output %h in test %s with no request pending", result_o, cur_test);
        cmp_errors++;
      end else begin
        exp_v = exp_q[rd_idx];
        rd_idx++;
        cmp_checks++;
        if ({status_o, result_o} !== exp_v) begin
          $display("FAILED %s: expected result %h status %b, actual result %h status %b",
                   cur_test, exp_v[31:0], exp_v[36:32], result_o, status_o);
          cmp_errors++;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles in test %s, %0d results never arrived",
               cycles, cur_test, exp_q.size() - rd_idx);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // Present one request on the falling edge and wait until it is taken.
  task automatic send_req(input logic [31:0] a, input logic [31:0] b, input logic is16,
                          input fpcmp_pkg::cmp_op_e op, input logic vec, input logic [1:0] mask);
    @(negedge clk_i);
    operand_a_i    = a;
    operand_b_i    = b;
    fmt_i          = is16 ? fpcmp_pkg::FP16 : fpcmp_pkg::FP32;
    op_i           = op;
    vectorial_op_i = vec;
    simd_mask_i    = mask;
    in_valid_i     = 1'b1;
    exp_q.push_back(ref_cmp(a, b, is16, op, vec, mask));
    do begin
      @(posedge clk_i);
    end while (!in_ready_o);
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    base_checks = cmp_checks + misc_checks;
    base_errors = cmp_errors + misc_errors;
  endtask

  // Stop requesting, wait for every result, then report the test.
  task automatic finish_test();
    @(negedge clk_i);
    in_valid_i = 1'b0;
    while (rd_idx < exp_q.size()) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
    $display("test %s: %0d checks, %0d errors", cur_test,
             cmp_checks + misc_checks - base_checks, cmp_errors + misc_errors - base_errors);
  endtask

  initial begin
    rst_ni         = 1'b0;
    operand_a_i    = '0;
    operand_b_i    = '0;
    fmt_i          = fpcmp_pkg::FP32;
    op_i           = EQ;
    vectorial_op_i = 1'b0;
    simd_mask_i    = 2'b11;
    in_valid_i     = 1'b0;
    one32   = make_fp32(1'b0, 8'd127, 23'd0);
    two32   = make_fp32(1'b0, 8'd128, 23'd0);
    mone32  = make_fp32(1'b1, 8'd127, 23'd0);
    nzero32 = make_fp32(1'b1, 8'd0, 23'd0);
    qnan32  = make_fp32(1'b0, 8'hFF, 23'h400000);
    snan32  = make_fp32(1'b0, 8'hFF, 23'h000001);
    one16   = make_fp16(1'b0, 5'd15, 10'd0);
    two16   = make_fp16(1'b0, 5'd16, 10'd0);
    mtwo16  = make_fp16(1'b1, 5'd16, 10'd0);
    qnan16  = make_fp16(1'b0, 5'h1F, 10'h200);
    snan16  = make_fp16(1'b0, 5'h1F, 10'h001);
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;

    start_test("reset");
    misc_checks += 2;
    if (out_valid_o !== 1'b0) begin
      $display("out_valid_o is not low after reset");
      misc_errors++;
    end
    if (in_ready_o !== 1'b1) begin
      $display("in_ready_o is not high after reset");
      misc_errors++;
    end
    finish_test();

    start_test("scalar_fp32");
    send_req(one32, one32, 1'b0, EQ, 1'b0, 2'b11);
    send_req(one32, two32, 1'b0, EQ, 1'b0, 2'b11);
    send_req(one32, two32, 1'b0, LT, 1'b0, 2'b11);
    send_req(two32, one32, 1'b0, LT, 1'b0, 2'b11);
    send_req(one32, one32, 1'b0, LE, 1'b0, 2'b11);
    send_req(mone32, one32, 1'b0, LT, 1'b0, 2'b11);
    send_req(two32, mone32, 1'b0, LE, 1'b0, 2'b11);
    send_req(32'd0, nzero32, 1'b0, EQ, 1'b0, 2'b11);
    send_req(32'd0, nzero32, 1'b0, LT, 1'b0, 2'b11);
    send_req(nzero32, 32'd0, 1'b0, LE, 1'b0, 2'b11);
    finish_test();

    start_test("vector_fp16");
    send_req({one16, two16}, {two16, one16}, 1'b1, LT, 1'b1, 2'b11);
    send_req({mtwo16, one16}, {mtwo16, two16}, 1'b1, EQ, 1'b1, 2'b11);
    send_req({two16, mtwo16}, {one16, one16}, 1'b1, LE, 1'b1, 2'b11);
    finish_test();

    // Upper operands would compare true, but the slot must stay zero.
    start_test("scalar_fp16");
    send_req({one16, two16}, {one16, one16}, 1'b1, EQ, 1'b0, 2'b11);
    send_req({one16, one16}, {two16, two16}, 1'b1, LT, 1'b0, 2'b11);
    finish_test();

    start_test("nan_rules");
    send_req(qnan32, one32, 1'b0, EQ, 1'b0, 2'b11);
    send_req(qnan32, one32, 1'b0, LT, 1'b0, 2'b11);
    send_req(one32, qnan32, 1'b0, LE, 1'b0, 2'b11);
    send_req(snan32, one32, 1'b0, EQ, 1'b0, 2'b11);
    send_req(snan32, one32, 1'b0, LT, 1'b0, 2'b11);
    send_req({16'd0, qnan16}, {16'd0, qnan16}, 1'b1, EQ, 1'b0, 2'b11);
    send_req({snan16, one16}, {one16, one16}, 1'b1, LE, 1'b1, 2'b11);
    finish_test();

    start_test("masking");
    send_req({qnan16, one16}, {one16, two16}, 1'b1, LT, 1'b1, 2'b01);
    send_req({snan16, one16}, {one16, one16}, 1'b1, EQ, 1'b1, 2'b01);
    send_req({one16, qnan16}, {two16, one16}, 1'b1, LT, 1'b1, 2'b10);
    finish_test();

    // Fill the buffer while the output is stalled.
    start_test("backpressure");
    ready_mode = 1;
    @(negedge clk_i);
    for (int i = 0; i < DEPTH; i++) begin
      send_req(one32 + 32'(i), one32, 1'b0, LE, 1'b0, 2'b11);
    end
    // The last job was taken at this rising edge, out_ready_i rises at the next falling one.
    ready_mode = 0;
    @(negedge clk_i);
    in_valid_i = 1'b0;
    misc_checks++;
    if (in_ready_o !== 1'b0) begin
      $display("in_ready_o stayed high with %0d jobs waiting", DEPTH);
      misc_errors++;
    end
    // The head result leaves at this edge.
    @(posedge clk_i);
    @(negedge clk_i);
    misc_checks++;
    if (in_ready_o !== 1'b1) begin
      $display("in_ready_o still low after a result was taken");
      misc_errors++;
    end
    finish_test();

    start_test("random");
    @(posedge clk_i);
    ready_mode = 2;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rnd_op = (rnd_ctl[i][9:8] == 2'd1) ? LT : ((rnd_ctl[i][9:8] == 2'd2) ? LE : EQ);
      send_req(rnd_a[i], rnd_b[i], rnd_ctl[i][0], rnd_op, rnd_ctl[i][1], rnd_ctl[i][11:10]);
    end
    ready_mode = 0;
    finish_test();

    $display("%0d checks, %0d errors", cmp_checks + misc_checks, cmp_errors + misc_errors);
    if (cmp_errors + misc_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
